//--- source/pcm_settings.svh
// shared sizes and register map; widths beyond 17-bit ROM or 14 registers are not supported
`ifndef PCM_SETTINGS_SVH
`define PCM_SETTINGS_SVH

// register file
`define PCM_NREGS      14
`define PCM_ADDR_W     4
`define PCM_DATA_W     8

// write strobes to these start a channel
`define PCM_REG_PLAY_A 5
`define PCM_REG_PLAY_B 11
// gains, channel A in the high nibble
`define PCM_REG_GAIN   12
// loop enables, bit 0 for A and bit 1 for B
`define PCM_REG_LOOP   13

// datapath widths
`define PCM_ROM_AW     17
`define PCM_PRE_W      12
`define PCM_GAIN_W     4
`define PCM_SMP_W      7
`define PCM_MIX_W      12

// unsigned byte to two's complement
`define PCM_OFFSET     'h40

// cen pulses per E/Q cycle
`define PCM_CEN_DIV    4

`endif

//--- source/pcm_pkg.sv
// types only; prescaler mode code 2'b11 is folded into pre_low8 by the register decode
package pcm_pkg;

    // channel playback state
    typedef enum logic {
        ch_idle = 1'b0,
        ch_busy = 1'b1
    } chan_state_e;

    // prescaler counter length, from bits 5:4 of the high prescaler register
    typedef enum logic [1:0] {
        // whole 12-bit counter, overflow at 0xfff
        pre_full = 2'b00,
        // overflow when the low byte is all ones
        pre_low8 = 2'b01,
        // counter and address advance in independent nibbles
        pre_nib  = 2'b10
    } pre_mode_e;

endpackage

//--- source/pcm_ctrl_if.sv
// one channel's control set, driven by the register file only
`include "pcm_settings.svh"

interface pcm_ctrl_if;

    // first byte address of the sample
    logic [`PCM_ROM_AW-1:0] rom_start;
    // prescaler reload value
    logic [`PCM_PRE_W-1:0]  pre0;
    // counter length mode
    pcm_pkg::pre_mode_e     pre_mode;
    // restart at rom_start on the end byte
    logic                   loop;
    // one-cycle start pulse
    logic                   play;

    modport regs (
        output rom_start, pre0, pre_mode, loop, play
    );

    modport chan (
        input rom_start, pre0, pre_mode, loop, play
    );

endinterface

//--- source/pcm_regs.sv
// no readback; writes to addresses 14 and 15 are dropped; cen must pulse for enables to run
`include "pcm_settings.svh"

module pcm_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   dacs,
    input  logic [`PCM_ADDR_W-1:0] addr,
    input  logic [`PCM_DATA_W-1:0] din,
    pcm_ctrl_if.regs               ctrl_a,
    pcm_ctrl_if.regs               ctrl_b,
    output logic [`PCM_GAIN_W-1:0] gain_a,
    output logic [`PCM_GAIN_W-1:0] gain_b,
    output logic                   tick,
    output logic                   cen_e,
    output logic                   cen_q
);

    localparam int CEN_CW = $clog2(`PCM_CEN_DIV);

    logic [`PCM_DATA_W-1:0] regs [`PCM_NREGS];
    logic                   play_a;
    logic                   play_b;
    logic [CEN_CW-1:0]      cen_cnt;
    logic                   div2;

    // bit 4 wins over bit 5, so code 3 behaves as low8
    function automatic pcm_pkg::pre_mode_e decode_mode(input logic [1:0] sel);
        if (sel[0]) begin
            return pcm_pkg::pre_low8;
        end else if (sel[1]) begin
            return pcm_pkg::pre_nib;
        end
        return pcm_pkg::pre_full;
    endfunction

    // register writes and play strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PCM_NREGS; i++) begin
                regs[i] <= '0;
            end
            play_a <= 1'b0;
            play_b <= 1'b0;
        end else begin
            // strobe is the write enable, no handshake
            if (dacs && addr < `PCM_NREGS) begin
                regs[addr] <= din;
            end
            play_a <= dacs && addr == `PCM_ADDR_W'(`PCM_REG_PLAY_A);
            play_b <= dacs && addr == `PCM_ADDR_W'(`PCM_REG_PLAY_B);
        end
    end

    // channel A map, regs 0..4
    assign ctrl_a.pre0      = {regs[1][3:0], regs[0]};
    assign ctrl_a.pre_mode  = decode_mode(regs[1][5:4]);
    assign ctrl_a.rom_start = {regs[4][0], regs[3], regs[2]};
    assign ctrl_a.loop      = regs[`PCM_REG_LOOP][0];
    assign ctrl_a.play      = play_a;

    // channel B map, same layout from reg 6
    assign ctrl_b.pre0      = {regs[7][3:0], regs[6]};
    assign ctrl_b.pre_mode  = decode_mode(regs[7][5:4]);
    assign ctrl_b.rom_start = {regs[10][0], regs[9], regs[8]};
    assign ctrl_b.loop      = regs[`PCM_REG_LOOP][1];
    assign ctrl_b.play      = play_b;

    assign gain_a = regs[`PCM_REG_GAIN][7:4];
    assign gain_b = regs[`PCM_REG_GAIN][3:0];

    // E and Q enables at a quarter of cen, half a period apart
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            cen_e   <= 1'b0;
            cen_q   <= 1'b0;
            div2    <= 1'b0;
            tick    <= 1'b0;
        end else begin
            if (cen) begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            cen_q <= cen && cen_cnt == CEN_CW'(1);
            cen_e <= cen && cen_cnt == CEN_CW'(`PCM_CEN_DIV - 1);
            // channel tick on every other Q slot
            tick  <= cen && cen_cnt == CEN_CW'(1) && div2;
            if (cen_q) begin
                div2 <= ~div2;
            end
        end
    end

endmodule

//--- source/pcm_channel.sv
// one sample per accepted overflow; a slow ROM delays the sample, it is never skipped
`include "pcm_settings.svh"

module pcm_channel (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick,
    pcm_ctrl_if.chan               ctrl,
    output logic [`PCM_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [`PCM_DATA_W-1:0] rom_dout,
    input  logic                   rom_ok,
    output logic [`PCM_SMP_W-1:0]  snd_ch
);

    pcm_pkg::chan_state_e   state;
    logic [`PCM_PRE_W-1:0]  cnt;
    logic                   play_l;
    logic                   pend;
    logic                   over;
    logic                   fire;
    logic                   is_nib;
    logic [`PCM_SMP_W-1:0]  smp_conv;
    logic [`PCM_ROM_AW-1:0] addr_next;

    assign is_nib = ctrl.pre_mode == pcm_pkg::pre_nib;

    // overflow point depends on counter length
    always_comb begin
        case (ctrl.pre_mode)
            pcm_pkg::pre_low8: over = &cnt[7:0];
            pcm_pkg::pre_nib:  over = &cnt[11:8];
            default:           over = &cnt;
        endcase
    end

    // overflow now or one left over from a ROM stall
    assign fire = tick && state == pcm_pkg::ch_busy && (over || pend);

    // byte minus offset, wraps mod 128
    assign smp_conv = rom_dout[`PCM_SMP_W-1:0] - `PCM_SMP_W'(`PCM_OFFSET);

    // nibble mode carries stay inside each group, top group is 5 bits
    // top group steps by 0x11, so bits 12 and 16 both advance
    always_comb begin
        if (is_nib) begin
            addr_next[3:0]              = rom_addr[3:0] + 1'b1;
            addr_next[7:4]              = rom_addr[7:4] + 1'b1;
            addr_next[11:8]             = rom_addr[11:8] + 1'b1;
            addr_next[`PCM_ROM_AW-1:12] = rom_addr[`PCM_ROM_AW-1:12] + 5'h11;
        end else begin
            addr_next = rom_addr + 1'b1;
        end
    end

    assign rom_cs = state == pcm_pkg::ch_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= pcm_pkg::ch_idle;
            cnt      <= '0;
            play_l   <= 1'b0;
            pend     <= 1'b0;
            rom_addr <= '0;
            snd_ch   <= '0;
        end else begin
            play_l <= ctrl.play;
            // prescaler
            if (tick) begin
                if (over) begin
                    cnt <= ctrl.pre0;
                end else if (is_nib) begin
                    cnt[7:0]  <= cnt[7:0] + 1'b1;
                    cnt[11:8] <= cnt[11:8] + 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            // sample fetch
            if (fire) begin
                if (rom_ok) begin
                    pend   <= 1'b0;
                    snd_ch <= smp_conv;
                    if (rom_dout[`PCM_DATA_W-1]) begin
                        // end marker
                        if (ctrl.loop) begin
                            rom_addr <= ctrl.rom_start;
                        end else begin
                            state <= pcm_pkg::ch_idle;
                        end
                    end else begin
                        rom_addr <= addr_next;
                    end
                end else begin
                    // data not ready, retry next tick
                    pend <= 1'b1;
                end
            end
            // silent when stopped
            if (state == pcm_pkg::ch_idle) begin
                snd_ch <= '0;
            end
            // start on play rising edge, restarts a busy channel too
            if (ctrl.play && !play_l) begin
                state    <= pcm_pkg::ch_busy;
                rom_addr <= ctrl.rom_start;
                cnt      <= ctrl.pre0;
                pend     <= 1'b0;
            end
        end
    end

endmodule

//--- source/pcm_mixer.sv
// gains are unsigned 0..15; the 12-bit sum cannot overflow at full scale
`include "pcm_settings.svh"

module pcm_mixer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic signed [`PCM_SMP_W-1:0] snda,
    input  logic signed [`PCM_SMP_W-1:0] sndb,
    input  logic [`PCM_GAIN_W-1:0]       gain_a,
    input  logic [`PCM_GAIN_W-1:0]       gain_b,
    output logic signed [`PCM_MIX_W-1:0] snd
);

    logic signed [`PCM_MIX_W-1:0] prod_a;
    logic signed [`PCM_MIX_W-1:0] prod_b;

    // zero bit keeps the gain positive in signed math
    assign prod_a = snda * $signed({1'b0, gain_a});
    assign prod_b = sndb * $signed({1'b0, gain_b});

    // one cycle from channel samples to output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd <= '0;
        end else begin
            snd <= prod_a + prod_b;
        end
    end

endmodule

//--- source/pcm_core.sv
// two ROM buses, one per channel; no sample RAM, no readback, no 2 MHz pin
`include "pcm_settings.svh"

module pcm_core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,
    // CPU write bus
    input  logic                         dacs,
    input  logic [`PCM_ADDR_W-1:0]       addr,
    input  logic [`PCM_DATA_W-1:0]       din,
    // CPU clock enables
    output logic                         cen_e,
    output logic                         cen_q,
    // channel A ROM
    output logic [`PCM_ROM_AW-1:0]       roma_addr,
    output logic                         roma_cs,
    input  logic [`PCM_DATA_W-1:0]       roma_dout,
    input  logic                         roma_ok,
    // channel B ROM
    output logic [`PCM_ROM_AW-1:0]       romb_addr,
    output logic                         romb_cs,
    input  logic [`PCM_DATA_W-1:0]       romb_dout,
    input  logic                         romb_ok,
    // raw and mixed sound
    output logic [`PCM_SMP_W-1:0]        snda,
    output logic [`PCM_SMP_W-1:0]        sndb,
    output logic signed [`PCM_MIX_W-1:0] snd
);

    logic [`PCM_GAIN_W-1:0] gain_a;
    logic [`PCM_GAIN_W-1:0] gain_b;
    logic                   tick;

    pcm_ctrl_if ctrl_a ();
    pcm_ctrl_if ctrl_b ();

    pcm_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .dacs   (dacs),
        .addr   (addr),
        .din    (din),
        .ctrl_a (ctrl_a.regs),
        .ctrl_b (ctrl_b.regs),
        .gain_a (gain_a),
        .gain_b (gain_b),
        .tick   (tick),
        .cen_e  (cen_e),
        .cen_q  (cen_q)
    );

    pcm_channel u_cha (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .ctrl     (ctrl_a.chan),
        .rom_addr (roma_addr),
        .rom_cs   (roma_cs),
        .rom_dout (roma_dout),
        .rom_ok   (roma_ok),
        .snd_ch   (snda)
    );

    pcm_channel u_chb (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .ctrl     (ctrl_b.chan),
        .rom_addr (romb_addr),
        .rom_cs   (romb_cs),
        .rom_dout (romb_dout),
        .rom_ok   (romb_ok),
        .snd_ch   (sndb)
    );

    // channel samples are two's complement
    pcm_mixer u_mix (
        .clk    (clk),
        .rst    (rst),
        .snda   ($signed(snda)),
        .sndb   ($signed(sndb)),
        .gain_a (gain_a),
        .gain_b (gain_b),
        .snd    (snd)
    );

endmodule

//--- test/pcm_core_chk.sv
// bound into pcm_core; reads the internal tick and gain nets, so those names must stay
`include "pcm_settings.svh"

module pcm_core_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         tick,
    input logic                         cen_e,
    input logic                         cen_q,
    input logic                         roma_cs,
    input logic                         romb_cs,
    input logic                         roma_ok,
    input logic                         romb_ok,
    input logic [`PCM_DATA_W-1:0]       roma_dout,
    input logic [`PCM_DATA_W-1:0]       romb_dout,
    input logic [`PCM_GAIN_W-1:0]       gain_a,
    input logic [`PCM_GAIN_W-1:0]       gain_b,
    input logic [`PCM_SMP_W-1:0]        snda,
    input logic [`PCM_SMP_W-1:0]        sndb,
    input logic signed [`PCM_MIX_W-1:0] snd
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned           fail_cnt = 0;
    logic [`PCM_MIX_W-1:0] mix_model;

    // 7-bit two's complement to int
    function automatic int smp_to_int(input logic [`PCM_SMP_W-1:0] v);
        return v[`PCM_SMP_W-1] ? int'(v) - (1 << `PCM_SMP_W) : int'(v);
    endfunction

    // weighted sum as it should leave the mixer a cycle later
    assign mix_model = `PCM_MIX_W'(smp_to_int(snda) * int'(gain_a)
                                   + smp_to_int(sndb) * int'(gain_b));

    // E and Q are half a period apart
    a_cen_apart: assert property (@(posedge clk) disable iff (rst) !(cen_e && cen_q))
        else begin
            fail_cnt++;
            $error("cen_e and cen_q were high in the same cycle");
        end

    // chip select only drops after an accepted end byte
    a_csa_end: assert property (@(posedge clk) disable iff (rst)
        $fell(roma_cs) |-> $past(tick && roma_ok && roma_dout[`PCM_DATA_W-1]))
        else begin
            fail_cnt++;
            $error("roma_cs fell without an accepted end byte");
        end

    a_csb_end: assert property (@(posedge clk) disable iff (rst)
        $fell(romb_cs) |-> $past(tick && romb_ok && romb_dout[`PCM_DATA_W-1]))
        else begin
            fail_cnt++;
            $error("romb_cs fell without an accepted end byte");
        end

    a_mix: assert property (@(posedge clk) disable iff (rst) snd == $past(mix_model))
        else begin
            fail_cnt++;
            $error("snd is not the weighted sum of the previous samples");
        end

endmodule

bind pcm_core pcm_core_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .tick      (tick),
    .cen_e     (cen_e),
    .cen_q     (cen_q),
    .roma_cs   (roma_cs),
    .romb_cs   (romb_cs),
    .roma_ok   (roma_ok),
    .romb_ok   (romb_ok),
    .roma_dout (roma_dout),
    .romb_dout (romb_dout),
    .gain_a    (gain_a),
    .gain_b    (gain_b),
    .snda      (snda),
    .sndb      (sndb),
    .snd       (snd)
);

//--- test/tb_pcm_core.sv
// directed run with random ROM stalls; ROM models decode only address bits 7:0
`include "pcm_settings.svh"

module tb_pcm_core;
    timeunit 1ns;
    timeprecision 100ps;

    // check run after a table write
    localparam logic [3:0] K_NONE = 4'd0;
    localparam logic [3:0] K_ONE  = 4'd1;
    localparam logic [3:0] K_LOOP = 4'd2;
    localparam logic [3:0] K_NIB  = 4'd3;
    localparam logic [3:0] K_MIX  = 4'd4;
    localparam int         NSTIM  = 20;
    localparam int         TMO    = 400;

    typedef struct packed {
        logic [`PCM_ADDR_W-1:0] addr;
        logic [`PCM_DATA_W-1:0] data;
        logic [3:0]             kind;
        logic [`PCM_ROM_AW-1:0] expv;
    } stim_t;

    logic                         clk = 1'b0;
    logic                         rst, cen, dacs, roma_ok, romb_ok, bit_0;
    logic [`PCM_ADDR_W-1:0]       addr;
    logic [`PCM_DATA_W-1:0]       din, roma_dout, romb_dout;
    logic [`PCM_ROM_AW-1:0]       roma_addr, romb_addr;
    logic                         roma_cs, romb_cs, cen_e, cen_q;
    logic [`PCM_SMP_W-1:0]        snda, sndb;
    logic signed [`PCM_MIX_W-1:0] snd;
    logic [7:0]                   rom_a [256];
    logic [7:0]                   rom_b [256];
    logic [15:0]                  lfsr = 16'd35;
    int                           mism = 0;
    int                           touts = 0;
    int                           n_e, n_q, n_both;

    // A one-shot full mode at 0x10, B loop low8 at 0x20, A nibble at 0, then gains
    stim_t stim [NSTIM] = '{
        '{4'd0,  8'hff, K_NONE, 17'h0},
        '{4'd1,  8'h0f, K_NONE, 17'h0},
        '{4'd2,  8'h10, K_NONE, 17'h0},
        '{4'd3,  8'h00, K_NONE, 17'h0},
        '{4'd4,  8'h00, K_NONE, 17'h0},
        '{4'd5,  8'h00, K_ONE,  17'h10},
        '{4'd6,  8'hff, K_NONE, 17'h0},
        '{4'd7,  8'h10, K_NONE, 17'h0},
        '{4'd8,  8'h20, K_NONE, 17'h0},
        '{4'd9,  8'h00, K_NONE, 17'h0},
        '{4'd10, 8'h00, K_NONE, 17'h0},
        '{4'd13, 8'h02, K_NONE, 17'h0},
        '{4'd11, 8'h00, K_LOOP, 17'h20},
        '{4'd0,  8'h00, K_NONE, 17'h0},
        '{4'd1,  8'h2f, K_NONE, 17'h0},
        '{4'd2,  8'h00, K_NONE, 17'h0},
        '{4'd3,  8'h00, K_NONE, 17'h0},
        '{4'd4,  8'h00, K_NONE, 17'h0},
        '{4'd5,  8'h00, K_NIB,  17'h11111},
        '{4'd12, 8'h9c, K_MIX,  17'h0}
    };

    pcm_core u_pcm_core (.*);

    // ROMs answer in the same cycle
    assign roma_dout = rom_a[roma_addr[7:0]];
    assign romb_dout = rom_b[romb_addr[7:0]];

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // ok drops when two fresh bits are both one
    always @(posedge clk) begin
        #2;
        lfsr    = lfsr_step(lfsr);
        bit_0   = lfsr[0];
        lfsr    = lfsr_step(lfsr);
        roma_ok = !(bit_0 && lfsr[0]);
        lfsr    = lfsr_step(lfsr);
        bit_0   = lfsr[0];
        lfsr    = lfsr_step(lfsr);
        romb_ok = !(bit_0 && lfsr[0]);
    end

    // low seven bits minus the offset, wrapping at 128
    function automatic logic [6:0] to_sample(input logic [7:0] b);
        return 7'((int'(b[6:0]) - `PCM_OFFSET + 128) % 128);
    endfunction

    function automatic logic [7:0] rom_byte(input int ch, input int idx);
        return ch ? rom_b[idx % 256] : rom_a[idx % 256];
    endfunction

    function automatic logic [11:0] mix_expect(input logic [6:0] a, input logic [6:0] b,
                                               input logic [3:0] ga, input logic [3:0] gb);
        int sa;
        int sb;
        sa = a[6] ? int'(a) - 128 : int'(a);
        sb = b[6] ? int'(b) - 128 : int'(b);
        return 12'(sa * int'(ga) + sb * int'(gb));
    endfunction

    // one cycle, inputs change 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [31:0] act,
                             input logic [31:0] expv);
        if (act !== expv) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, expv);
            mism++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        touts++;
    endtask

    // single-cycle strobe write
    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        dacs = 1'b1;
        addr = a;
        din  = d;
        step();
        dacs = 1'b0;
    endtask

    // every sample change is checked against the ROM byte it came from
    task automatic follow_samples(input int ch, input logic [`PCM_ROM_AW-1:0] start,
                                  input int passes);
        int         idx;
        int         seen;
        int         n;
        logic [6:0] cur;
        logic [6:0] last;
        logic [7:0] b;
        n = 0;
        while (!(ch ? romb_cs : roma_cs) && n < TMO) begin
            step();
            n++;
        end
        if (!(ch ? romb_cs : roma_cs)) begin
            report_timeout("the channel to start");
            return;
        end
        idx  = start;
        seen = 0;
        last = ch ? sndb : snda;
        while (seen < passes) begin
            n   = 0;
            cur = last;
            while (cur == last && n < TMO) begin
                step();
                n++;
                cur = ch ? sndb : snda;
            end
            if (cur == last) begin
                report_timeout("the next sample");
                return;
            end
            b = rom_byte(ch, idx);
            check_val(ch ? "sndb" : "snda", cur, to_sample(b));
            last = cur;
            idx++;
            if (b[7]) begin
                // end marker, either stop or restart
                seen++;
                idx = start;
                check_val(ch ? "romb_cs" : "roma_cs", ch ? romb_cs : roma_cs, passes > 1);
                if (passes > 1) begin
                    check_val(ch ? "romb_addr" : "roma_addr", ch ? romb_addr : roma_addr, start);
                end
            end
        end
        if (passes == 1) begin
            n = 0;
            while ((ch ? sndb : snda) != 0 && n < TMO) begin
                step();
                n++;
            end
            check_val(ch ? "sndb" : "snda", ch ? sndb : snda, 0);
        end
    endtask

    // first address step in nibble mode
    task automatic check_nib(input logic [`PCM_ROM_AW-1:0] expv);
        int n;
        n = 0;
        while (!roma_cs && n < TMO) begin
            step();
            n++;
        end
        n = 0;
        while (roma_cs && roma_addr == 0 && n < TMO) begin
            step();
            n++;
        end
        if (roma_cs && roma_addr != 0) begin
            check_val("roma_addr", roma_addr, expv);
        end else begin
            report_timeout("the nibble address step");
        end
    endtask

    // output follows last cycle's samples and the written gains
    task automatic check_mix(input logic [7:0] g);
        logic [6:0] pa;
        logic [6:0] pb;
        pa = snda;
        pb = sndb;
        repeat (40) begin
            step();
            check_val("snd", $unsigned(snd), mix_expect(pa, pb, g[7:4], g[3:0]));
            pa = snda;
            pb = sndb;
        end
    endtask

    initial begin
        rst     = 1'b1;
        cen     = 1'b1;
        dacs    = 1'b0;
        addr    = '0;
        din     = '0;
        roma_ok = 1'b1;
        romb_ok = 1'b1;
        for (int i = 0; i < 256; i++) begin
            // step of 3 or 5 mod 127 keeps adjacent bytes distinct and bit 7 clear
            rom_a[i] = 8'((i * 3 + 7) % 127);
            rom_b[i] = 8'((i * 5 + 11) % 127);
        end
        rom_a[8'h13] = 8'h85;
        rom_b[8'h22] = 8'h9a;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        check_val("cen_e", cen_e, 0);
        check_val("cen_q", cen_q, 0);
        check_val("roma_cs", roma_cs, 0);
        check_val("romb_cs", romb_cs, 0);
        check_val("snd", $unsigned(snd), 0);
        check_val("snda", snda, 0);
        check_val("sndb", sndb, 0);
        n_e    = 0;
        n_q    = 0;
        n_both = 0;
        repeat (64) begin
            step();
            n_e    += int'(cen_e);
            n_q    += int'(cen_q);
            n_both += int'(cen_e && cen_q);
        end
        check_val("cen_e pulses", n_e, 16);
        check_val("cen_q pulses", n_q, 16);
        check_val("cen_e and cen_q overlap", n_both, 0);
        for (int i = 0; i < NSTIM; i++) begin
            write_reg(stim[i].addr, stim[i].data);
            case (stim[i].kind)
                K_ONE:   follow_samples(0, stim[i].expv, 1);
                K_LOOP:  follow_samples(1, stim[i].expv, 2);
                K_NIB:   check_nib(stim[i].expv);
                K_MIX:   check_mix(stim[i].data);
                default: ;
            endcase
        end
        $display("errors: %0d mismatch, %0d timeout, %0d assertion",
                 mism, touts, u_pcm_core.u_chk.fail_cnt);
        if (mism + touts + u_pcm_core.u_chk.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/pcm_pkg.sv
source/pcm_ctrl_if.sv
source/pcm_regs.sv
source/pcm_channel.sv
source/pcm_mixer.sv
source/pcm_core.sv
test/pcm_core_chk.sv
test/tb_pcm_core.sv
